//--- common/hwpf_defs.svh
`ifndef HWPF_DEFS_SVH
`define HWPF_DEFS_SVH

// Physical byte address
`define HWPF_PADDR_W       32

// 64-byte cache lines
`define HWPF_LINE_OFFSET_W 6

// Signed stride, counted in lines
`define HWPF_STRIDE_W      16

// Prefetches per trigger
`define HWPF_NBLOCKS_W     4

// Idle cycles between two issues
`define HWPF_THROTTLE_W    8

// Prefetch request queue entries, also the initial credit count
`define HWPF_QUEUE_DEPTH   4

`endif

//--- common/hwpf_pkg.sv
`include "hwpf_defs.svh"

package hwpf_pkg;

  // Byte address and line number
  typedef logic [`HWPF_PADDR_W-1:0] paddr_t;
  typedef logic [`HWPF_PADDR_W-`HWPF_LINE_OFFSET_W-1:0] line_addr_t;

  // Stride in lines, may be negative
  typedef logic signed [`HWPF_STRIDE_W-1:0] stride_t;

  typedef logic [`HWPF_NBLOCKS_W-1:0] nblocks_t;   // Zero disables the burst
  typedef logic [`HWPF_THROTTLE_W-1:0] throttle_t; // Idle gap between issues

  // Must hold the full queue depth
  typedef logic [$clog2(`HWPF_QUEUE_DEPTH+1)-1:0] credit_t;

  typedef enum logic [1:0] {
    HWPF_IDLE,  // Watching the snoop ports
    HWPF_ISSUE, // Next push pending on a credit
    HWPF_WAIT   // Throttle gap
  } hwpf_state_e;

endpackage

//--- hwpf/hwpf_stride_engine.sv
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module hwpf_stride_engine (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ld_snoop_valid_i,
  input  hwpf_pkg::paddr_t    ld_snoop_addr_i,
  input  logic                st_snoop_valid_i,
  input  hwpf_pkg::paddr_t    st_snoop_addr_i,
  input  logic                base_set_i,
  input  hwpf_pkg::paddr_t    base_i,
  input  logic                param_set_i,
  input  hwpf_pkg::stride_t   stride_i,
  input  hwpf_pkg::nblocks_t  nblocks_i,
  input  logic                throttle_set_i,
  input  hwpf_pkg::throttle_t throttle_i,
  input  logic                credit_i,
  output hwpf_pkg::paddr_t    base_o,
  output hwpf_pkg::stride_t   stride_o,
  output hwpf_pkg::nblocks_t  nblocks_o,
  output hwpf_pkg::throttle_t throttle_o,
  output logic                status_busy_o,
  output logic                status_enabled_o,
  output logic                push_o,
  output hwpf_pkg::paddr_t    push_addr_o
);
  import hwpf_pkg::*;

  localparam int PADDR_W  = `HWPF_PADDR_W;
  localparam int OFFSET_W = `HWPF_LINE_OFFSET_W;
  localparam int LINE_W   = PADDR_W - OFFSET_W;
  localparam int STRIDE_W = `HWPF_STRIDE_W;

  // Configuration registers
  paddr_t    base_q;
  stride_t   stride_q;
  nblocks_t  nblocks_q;
  throttle_t throttle_q;
  logic      enabled_q;

  hwpf_state_e state_q, state_d;
  line_addr_t  next_line_q, next_line_d; // Line of the next push
  nblocks_t    remain_q, remain_d;       // Pushes left in this burst
  throttle_t   wait_cnt_q, wait_cnt_d;
  credit_t     credit_q;

  line_addr_t base_line;
  line_addr_t ld_line;
  line_addr_t st_line;
  line_addr_t stride_ext;
  logic       ld_hit;
  logic       st_hit;
  logic       trigger;
  logic       push;
  logic       last_push;

  assign base_line  = base_q[PADDR_W-1:OFFSET_W];
  assign ld_line    = ld_snoop_addr_i[PADDR_W-1:OFFSET_W];
  assign st_line    = st_snoop_addr_i[PADDR_W-1:OFFSET_W];
  assign stride_ext = {{(LINE_W-STRIDE_W){stride_q[STRIDE_W-1]}}, stride_q}; // Sign extend

  assign ld_hit = ld_snoop_valid_i && (ld_line == base_line);
  assign st_hit = st_snoop_valid_i && (st_line == base_line);

  // Both ports matching together is still a single trigger
  assign trigger = enabled_q && (state_q == HWPF_IDLE) && (ld_hit || st_hit) &&
                   (nblocks_q != '0);

  assign push      = (state_q == HWPF_ISSUE) && (credit_q != '0);
  assign last_push = push && (remain_q == nblocks_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      stride_q   <= '0;
      nblocks_q  <= '0;
      throttle_q <= '0;
      enabled_q  <= 1'b0;
    end else begin
      if (base_set_i) begin
        base_q    <= base_i;
        enabled_q <= 1'b1;
      end else if (last_push) begin
        base_q <= push_addr_o; // Stream continues from the last line
      end
      if (param_set_i) begin
        stride_q  <= stride_i;
        nblocks_q <= nblocks_i;
      end
      if (throttle_set_i) throttle_q <= throttle_i;
    end
  end

  always_comb begin
    state_d     = state_q;
    next_line_d = next_line_q;
    remain_d    = remain_q;
    wait_cnt_d  = wait_cnt_q;
    unique case (state_q)
      HWPF_IDLE: begin
        if (trigger) begin
          state_d     = HWPF_ISSUE;
          next_line_d = base_line + stride_ext;
          remain_d    = nblocks_q;
        end
      end
      HWPF_ISSUE: begin
        if (push) begin
          next_line_d = next_line_q + stride_ext; // Wraps modulo 2^26 lines
          remain_d    = remain_q - nblocks_t'(1);
          if (last_push) begin
            state_d = HWPF_IDLE;
          end else if (throttle_q != '0) begin
            state_d    = HWPF_WAIT;
            wait_cnt_d = throttle_q;
          end
        end
      end
      HWPF_WAIT: begin
        wait_cnt_d = wait_cnt_q - throttle_t'(1);
        if (wait_cnt_q == throttle_t'(1)) state_d = HWPF_ISSUE;
      end
      default: state_d = HWPF_IDLE;
    endcase
    if (base_set_i) state_d = HWPF_IDLE; // Reprogramming aborts any burst
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= HWPF_IDLE;
      remain_q   <= '0;
      wait_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      remain_q   <= remain_d;
      wait_cnt_q <= wait_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    next_line_q <= next_line_d;
  end

  // One credit per free queue entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_t'(`HWPF_QUEUE_DEPTH);
    end else begin
      unique case ({push, credit_i})
        2'b10:   credit_q <= credit_q - credit_t'(1);
        2'b01:   credit_q <= credit_q + credit_t'(1);
        default: credit_q <= credit_q; // Spend and return cancel out
      endcase
    end
  end

  assign push_o      = push;
  assign push_addr_o = {next_line_q, {OFFSET_W{1'b0}}}; // Line aligned

  assign base_o           = base_q;
  assign stride_o         = stride_q;
  assign nblocks_o        = nblocks_q;
  assign throttle_o       = throttle_q;
  assign status_busy_o    = (state_q != HWPF_IDLE);
  assign status_enabled_o = enabled_q;

endmodule

//--- hw/hwpf_req_queue.sv
`timescale 1ns/1ps

module hwpf_req_queue #(
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  hwpf_pkg::paddr_t push_addr_i,
  input  logic             pop_i,
  output logic             valid_o,
  output hwpf_pkg::paddr_t head_addr_o,
  output logic             credit_o
);
  import hwpf_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  paddr_t             mem_q [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               pop;
  logic               credit_q;

  // Producer never pushes without a credit, so no full check here
  assign pop = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_addr_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      unique case ({push_i, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
      credit_q <= pop; // Freed entry goes back to the engine
    end
  end

  assign valid_o     = (count_q != '0);
  assign head_addr_o = mem_q[rd_ptr_q];
  assign credit_o    = credit_q;

endmodule

//--- hw/mem_req_arbiter.sv
`timescale 1ns/1ps

module mem_req_arbiter (
  // Demand miss, always first
  input  logic             miss_valid_i,
  input  hwpf_pkg::paddr_t miss_addr_i,
  output logic             miss_ready_o,

  // Head of the prefetch queue
  input  logic             q_valid_i,
  input  hwpf_pkg::paddr_t q_addr_i,
  output logic             q_pop_o,

  // Merged memory request
  output logic             mem_req_valid_o,
  output hwpf_pkg::paddr_t mem_req_addr_o,
  output logic             mem_req_is_pf_o,
  input  logic             mem_req_ready_i
);

  logic pf_sel;

  // Prefetch wins only when no miss is waiting
  assign pf_sel = q_valid_i && !miss_valid_i;

  assign mem_req_valid_o = miss_valid_i || q_valid_i;
  assign mem_req_addr_o  = miss_valid_i ? miss_addr_i : q_addr_i;
  assign mem_req_is_pf_o = pf_sel;

  // Memory readiness passes straight to the miss source
  assign miss_ready_o = mem_req_ready_i;

  // Head leaves the queue only on an accepted transfer
  assign q_pop_o = pf_sel && mem_req_ready_i;

endmodule

//--- hw/hwpf_subsystem.sv
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module hwpf_subsystem (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Accepted load and store accesses
  input  logic                ld_snoop_valid_i,
  input  hwpf_pkg::paddr_t    ld_snoop_addr_i,
  input  logic                st_snoop_valid_i,
  input  hwpf_pkg::paddr_t    st_snoop_addr_i,

  // Prefetcher configuration
  input  logic                base_set_i,
  input  hwpf_pkg::paddr_t    base_i,
  input  logic                param_set_i,
  input  hwpf_pkg::stride_t   stride_i,
  input  hwpf_pkg::nblocks_t  nblocks_i,
  input  logic                throttle_set_i,
  input  hwpf_pkg::throttle_t throttle_i,
  output hwpf_pkg::paddr_t    base_o,
  output hwpf_pkg::stride_t   stride_o,
  output hwpf_pkg::nblocks_t  nblocks_o,
  output hwpf_pkg::throttle_t throttle_o,
  output logic                status_busy_o,
  output logic                status_enabled_o,

  // Demand misses from the cache
  input  logic                miss_valid_i,
  input  hwpf_pkg::paddr_t    miss_addr_i,
  output logic                miss_ready_o,

  // Memory request port
  output logic                mem_req_valid_o,
  output hwpf_pkg::paddr_t    mem_req_addr_o,
  output logic                mem_req_is_pf_o,
  input  logic                mem_req_ready_i
);
  import hwpf_pkg::*;

  logic   pf_push;   // Engine to queue
  paddr_t pf_addr;
  logic   pf_credit; // Queue back to engine
  logic   q_valid;   // Queue head to arbiter
  paddr_t q_addr;
  logic   q_pop;

  hwpf_stride_engine i_engine (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ld_snoop_valid_i (ld_snoop_valid_i),
    .ld_snoop_addr_i  (ld_snoop_addr_i),
    .st_snoop_valid_i (st_snoop_valid_i),
    .st_snoop_addr_i  (st_snoop_addr_i),
    .base_set_i       (base_set_i),
    .base_i           (base_i),
    .param_set_i      (param_set_i),
    .stride_i         (stride_i),
    .nblocks_i        (nblocks_i),
    .throttle_set_i   (throttle_set_i),
    .throttle_i       (throttle_i),
    .credit_i         (pf_credit),
    .base_o           (base_o),
    .stride_o         (stride_o),
    .nblocks_o        (nblocks_o),
    .throttle_o       (throttle_o),
    .status_busy_o    (status_busy_o),
    .status_enabled_o (status_enabled_o),
    .push_o           (pf_push),
    .push_addr_o      (pf_addr)
  );

  hwpf_req_queue #(
    .DEPTH (`HWPF_QUEUE_DEPTH)
  ) i_req_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (pf_push),
    .push_addr_i (pf_addr),
    .pop_i       (q_pop),
    .valid_o     (q_valid),
    .head_addr_o (q_addr),
    .credit_o    (pf_credit)
  );

  mem_req_arbiter i_mem_arbiter (
    .miss_valid_i    (miss_valid_i),
    .miss_addr_i     (miss_addr_i),
    .miss_ready_o    (miss_ready_o),
    .q_valid_i       (q_valid),
    .q_addr_i        (q_addr),
    .q_pop_o         (q_pop),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_is_pf_o (mem_req_is_pf_o),
    .mem_req_ready_i (mem_req_ready_i)
  );

endmodule

//--- dv/hwpf_subsystem_sva.sv
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module hwpf_subsystem_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic mem_req_valid_i,
  input logic mem_req_ready_i,
  input logic pf_push_i,
  input logic pf_credit_i,
  input logic q_pop_i,
  input logic status_busy_i
);
  import hwpf_pkg::*;

  credit_t credit_cnt; // Own copy of the engine credit count
  credit_t q_occ;      // Entries pushed and not yet popped
  int      fail_count;

  initial fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_cnt <= credit_t'(`HWPF_QUEUE_DEPTH);
      q_occ      <= '0;
    end else begin
      credit_cnt <= credit_cnt - credit_t'(pf_push_i) + credit_t'(pf_credit_i);
      q_occ      <= q_occ + credit_t'(pf_push_i) - credit_t'(q_pop_i);
    end
  end

  // Request stays up until memory takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i)
    else begin
      $error("Memory request valid dropped before ready");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_push_i |-> credit_cnt != '0)
    else begin
      $error("Engine pushed a prefetch without a credit");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) q_pop_i |-> q_occ != '0)
    else begin
      $error("Queue popped while empty");
      fail_count++;
    end

  assert property (@(posedge clk_i) $rose(rst_ni) |-> !status_busy_i)
    else begin
      $error("Engine busy right after reset");
      fail_count++;
    end

endmodule

bind hwpf_subsystem hwpf_subsystem_sva i_sva (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_ready_i (mem_req_ready_i),
  .pf_push_i       (pf_push),
  .pf_credit_i     (pf_credit),
  .q_pop_i         (q_pop),
  .status_busy_i   (status_busy_o)
);

//--- dv/hwpf_subsystem_tb.sv
`timescale 1ns/1ps
`include "hwpf_defs.svh"

module hwpf_subsystem_tb;
  import hwpf_pkg::*;

  localparam int MAX_CYCLES = 4000; // Five tests of up to 600 cycles plus margin
  localparam int OFF_W      = `HWPF_LINE_OFFSET_W;
  localparam int LINE_W     = `HWPF_PADDR_W - `HWPF_LINE_OFFSET_W;

  logic clk_i, rst_ni;
  logic ld_snoop_valid_i, st_snoop_valid_i, base_set_i, param_set_i, throttle_set_i;
  paddr_t ld_snoop_addr_i, st_snoop_addr_i, base_i, base_o;
  stride_t stride_i, stride_o;
  nblocks_t nblocks_i, nblocks_o;
  throttle_t throttle_i, throttle_o;
  logic status_busy_o, status_enabled_o;
  logic miss_valid_i, miss_ready_o;
  paddr_t miss_addr_i, mem_req_addr_o;
  logic mem_req_valid_o, mem_req_is_pf_o, mem_req_ready_i;

  logic [31:0] lfsr_q;
  int          errors, checks, cycle_cnt, pf_seen, miss_seen, last_pf_cycle;
  string       test_name;
  paddr_t      pf_exp[$];
  paddr_t      miss_exp[$];
  paddr_t      cur_base;   // Base line the engine should hold
  stride_t     cfg_stride;
  nblocks_t    cfg_nblocks;
  throttle_t   cfg_throttle;
  int          ready_mode; // 0 always ready, 1 random, 2 held low
  logic        gap_check_en, have_last_pf;

  hwpf_subsystem UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Fibonacci LFSR stepped once per bit with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Queues the expected burst and returns the base left behind
  function automatic paddr_t ref_burst(paddr_t base, stride_t stride, nblocks_t nb);
    longint line;
    paddr_t addr;
    line = longint'(base >> OFF_W);
    addr = base;
    for (int k = 0; k < int'(nb); k++) begin
      line = (line + longint'(stride)) & ((longint'(1) << LINE_W) - 1); // Modulo 2^26
      addr = paddr_t'(line << OFF_W);
      pf_exp.push_back(addr);
    end
    return addr;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, name, expected, actual);
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic write_param(stride_t stride, nblocks_t nb);
    param_set_i = 1'b1;
    stride_i    = stride;
    nblocks_i   = nb;
    cfg_stride  = stride;
    cfg_nblocks = nb;
    tick();
    param_set_i = 1'b0;
    check_value("stride readback", 32'(stride), 32'(stride_o));
    check_value("nblocks readback", 32'(nb), 32'(nblocks_o));
  endtask

  task automatic write_throttle(throttle_t t);
    throttle_set_i = 1'b1;
    throttle_i     = t;
    cfg_throttle   = t;
    tick();
    throttle_set_i = 1'b0;
    check_value("throttle readback", 32'(t), 32'(throttle_o));
  endtask

  task automatic write_base(paddr_t base);
    base_set_i = 1'b1;
    base_i     = base;
    cur_base   = base;
    tick();
    base_set_i = 1'b0;
    check_value("base readback", base, base_o);
    check_value("enabled after base write", 1, status_enabled_o);
  endtask

  task automatic snoop(logic ld, logic st, paddr_t addr);
    ld_snoop_valid_i = ld;
    st_snoop_valid_i = st;
    ld_snoop_addr_i  = addr;
    st_snoop_addr_i  = addr;
    tick();
    ld_snoop_valid_i = 1'b0;
    st_snoop_valid_i = 1'b0;
  endtask

  // Hits the current base at a random byte within its line
  task automatic trigger_burst(logic ld, logic st);
    logic [31:0] r;
    paddr_t      hit_addr;
    r        = rand_bits(OFF_W);
    hit_addr = {cur_base[`HWPF_PADDR_W-1:OFF_W], r[OFF_W-1:0]};
    cur_base = ref_burst(cur_base, cfg_stride, cfg_nblocks);
    snoop(ld, st, hit_addr);
  endtask

  task automatic send_miss(paddr_t addr);
    miss_exp.push_back(addr);
    miss_valid_i = 1'b1;
    miss_addr_i  = addr;
    do @(posedge clk_i); while (!miss_ready_o);
    #2;
    miss_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (pf_exp.size() != 0 || miss_exp.size() != 0 || status_busy_o) tick();
    repeat (4) tick(); // Room for a stray transfer to show up
  endtask

  task automatic random_param(nblocks_t nb);
    stride_t stride;
    stride = stride_t'(rand_bits(16));
    if (stride == '0) stride = stride_t'(1);
    if (nb == '0) nb = nblocks_t'(1);
    write_param(stride, nb);
  endtask

  // Every accepted memory transfer is checked here
  always @(posedge clk_i) begin : compare_transfers
    int gap;
    if (rst_ni) begin
      check_value("miss ready", mem_req_ready_i, miss_ready_o);
    end
    if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
      if (mem_req_is_pf_o) begin
        if (pf_exp.size() == 0) begin
          errors++;
          $display("%s: prefetch to %h arrived when none was due", test_name, mem_req_addr_o);
        end else begin
          check_value("prefetch address", pf_exp.pop_front(), mem_req_addr_o);
        end
        if (gap_check_en && have_last_pf) begin
          gap = cycle_cnt - last_pf_cycle;
          check_value("throttle gap", cfg_throttle + 1,
                      (gap > cfg_throttle) ? cfg_throttle + 1 : gap);
        end
        last_pf_cycle = cycle_cnt;
        have_last_pf  = 1'b1;
        pf_seen++;
      end else begin
        if (miss_exp.size() == 0) begin
          errors++;
          $display("%s: demand transfer to %h was never requested", test_name, mem_req_addr_o);
        end else begin
          check_value("miss address", miss_exp.pop_front(), mem_req_addr_o);
        end
        miss_seen++;
      end
    end
  end

  always @(posedge clk_i) begin
    #2;
    case (ready_mode)
      1:       mem_req_ready_i = rand_bits(1);
      2:       mem_req_ready_i = 1'b0;
      default: mem_req_ready_i = 1'b1;
    endcase
  end

  always @(negedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int     start;
    paddr_t old_base;
    lfsr_q = 32'h2c7d;
    {errors, checks, cycle_cnt, pf_seen, miss_seen, last_pf_cycle, ready_mode} = '0;
    {gap_check_en, have_last_pf} = '0;
    {ld_snoop_valid_i, st_snoop_valid_i, base_set_i, param_set_i, throttle_set_i} = '0;
    {ld_snoop_addr_i, st_snoop_addr_i, base_i, stride_i, nblocks_i, throttle_i} = '0;
    {miss_valid_i, miss_addr_i} = '0;
    mem_req_ready_i = 1'b1;
    rst_ni = 1'b0;
    test_name = "reset";
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_value("busy", 0, status_busy_o);
    check_value("memory valid", 0, mem_req_valid_o);
    check_value("enabled", 0, status_enabled_o);

    test_name = "config";
    write_param(stride_t'(3), nblocks_t'(2));
    write_throttle(throttle_t'(7));
    snoop(1'b1, 1'b0, paddr_t'(32'h24)); // Matches the reset base line
    repeat (20) tick();
    check_value("prefetches while disabled", 0, pf_seen);
    check_value("busy while disabled", 0, status_busy_o);
    write_throttle('0);
    write_base(paddr_t'(rand_bits(32)));

    test_name = "burst";
    random_param(nblocks_t'(rand_bits(4)));
    trigger_burst(1'b1, 1'b0);
    wait_drained();
    check_value("base after burst", cur_base, base_o);
    trigger_burst(1'b1, 1'b0); // Continues from the last line
    wait_drained();
    trigger_burst(1'b0, 1'b1);
    wait_drained();
    trigger_burst(1'b1, 1'b1); // Both ports give one trigger
    wait_drained();
    check_value("base after bursts", cur_base, base_o);

    test_name = "priority";
    start = miss_seen;
    random_param(nblocks_t'(8));
    trigger_burst(1'b1, 1'b0);
    for (int i = 0; i < 6; i++) begin
      repeat (rand_bits(2)) tick();
      send_miss(paddr_t'(rand_bits(32)));
    end
    wait_drained();
    check_value("miss transfers", 6, miss_seen - start);

    test_name = "backpressure";
    start = pf_seen;
    random_param(nblocks_t'(12));
    ready_mode = 2;
    trigger_burst(1'b0, 1'b1);
    repeat (40) tick();
    check_value("transfers while stalled", 0, pf_seen - start);
    check_value("busy while stalled", 1, status_busy_o);
    ready_mode = 1;
    wait_drained();
    ready_mode = 0;
    check_value("prefetch transfers", 12, pf_seen - start);

    test_name = "throttle";
    start = pf_seen;
    write_throttle(throttle_t'(rand_bits(3) + 2));
    random_param(nblocks_t'(6));
    have_last_pf = 1'b0;
    gap_check_en = 1'b1;
    old_base     = cur_base;
    trigger_burst(1'b1, 1'b0);
    while (status_busy_o) snoop(1'b1, 1'b1, old_base); // Ignored while busy
    wait_drained();
    gap_check_en = 1'b0;
    check_value("prefetch transfers", 6, pf_seen - start);

    test_name = "end";
    check_value("prefetches never seen", 0, pf_exp.size());
    errors += UUT.i_sva.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+common
common/hwpf_pkg.sv
hwpf/hwpf_stride_engine.sv
hw/hwpf_req_queue.sv
hw/mem_req_arbiter.sv
hw/hwpf_subsystem.sv
dv/hwpf_subsystem_sva.sv
dv/hwpf_subsystem_tb.sv

//--- Bender.yml
package:
  name: hwpf_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/hwpf_pkg.sv
      - hwpf/hwpf_stride_engine.sv
      - hw/hwpf_req_queue.sv
      - hw/mem_req_arbiter.sv
      - hw/hwpf_subsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/hwpf_subsystem_sva.sv
      - dv/hwpf_subsystem_tb.sv
